//--- source/mult_pkg.sv
`default_nettype none

package mult_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;
    localparam int STEP_WIDTH    = $clog2(OPERAND_WIDTH);

    // Multiplier MSB carries weight -2^15
    localparam int LAST_STEP     = OPERAND_WIDTH - 1;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic signed [OPERAND_WIDTH-1:0] operand_t;
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;
    typedef logic [STEP_WIDTH-1:0]           step_t;

    // One operand pair per transaction
    typedef struct packed {
        operand_t multiplicand;
        operand_t multiplier;
    } mult_request_t;

    typedef enum logic [1:0] {
        IDLE,
        STEP,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/mult_controller.sv
`timescale 1ns/1ps
`default_nettype none

module mult_controller
    import mult_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Input handshake
    input  logic  req_valid,
    output logic  req_ready,

    // Output handshake
    output logic  product_valid,
    input  logic  product_ready,

    // Datapath control
    output logic  load,
    output logic  step_en,
    output step_t step_index
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    step_t       step_count;
    step_t       next_step_count;

    logic accept;
    logic product_taken;
    logic last_step;

    ////////////////////////////////////////
    // Handshake events
    ////////////////////////////////////////

    assign accept        = req_valid && req_ready;
    assign product_taken = product_valid && product_ready;
    assign last_step     = (step_count == step_t'(LAST_STEP));

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = STEP;
                end
            end
            STEP: begin
                // Sixteen steps, then the product is complete
                if (last_step) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                // Hold the result until the consumer takes it
                if (product_taken) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Step counter wraps to zero after the last step
    always_comb begin
        next_step_count = step_count;
        if (accept) begin
            next_step_count = '0;
        end else if (state == STEP) begin
            next_step_count = step_count + 1'b1;
        end
    end

    ////////////////////////////////////////
    // State and counter registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= IDLE;
            step_count <= '0;
        end else begin
            state      <= next_state;
            step_count <= next_step_count;
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    // One operation at a time
    assign req_ready     = (state == IDLE);
    assign product_valid = (state == DONE);

    assign load          = accept;
    assign step_en       = (state == STEP);
    assign step_index    = step_count;

endmodule

`default_nettype wire

//--- source/shift_add_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_datapath
    import mult_pkg::*;
(
    input  logic          clk,
    input  logic          reset,

    // Control from the FSM
    input  logic          load,
    input  logic          step_en,
    input  step_t         step_index,

    // Operands and result
    input  mult_request_t req,
    output product_t      product
);

    operand_t multiplicand_q;
    operand_t multiplier_q;
    product_t accumulator;

    product_t multiplicand_ext;
    product_t selected_pp;
    product_t signed_pp;
    product_t shifted_pp;
    logic     sign_step;

    ////////////////////////////////////////
    // Operand registers
    ////////////////////////////////////////

    // Multiplier shifts right so bit 0 is the current bit
    always_ff @(posedge clk) begin
        if (load) begin
            multiplicand_q <= req.multiplicand;
            multiplier_q   <= req.multiplier;
        end else if (step_en) begin
            multiplier_q   <= multiplier_q >> 1;
        end
    end

    ////////////////////////////////////////
    // Partial product
    ////////////////////////////////////////

    assign sign_step = (step_index == step_t'(LAST_STEP));

    always_comb begin
        multiplicand_ext = {
            {(PRODUCT_WIDTH - OPERAND_WIDTH){multiplicand_q[OPERAND_WIDTH-1]}},
            multiplicand_q
        };

        // Zero when the multiplier bit is clear
        if (multiplier_q[0]) begin
            selected_pp = multiplicand_ext;
        end else begin
            selected_pp = '0;
        end

        // Top bit has negative weight in two's complement
        if (sign_step) begin
            signed_pp = -selected_pp;
        end else begin
            signed_pp = selected_pp;
        end

        shifted_pp = signed_pp << step_index;
    end

    ////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            accumulator <= '0;
        end else if (load) begin
            // Fresh start for every request
            accumulator <= '0;
        end else if (step_en) begin
            accumulator <= accumulator + shifted_pp;
        end
    end

    assign product = accumulator;

endmodule

`default_nettype wire

//--- source/seq_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier
    import mult_pkg::*;
(
    input  logic          clk,
    input  logic          reset,

    // Request port
    input  mult_request_t req,
    input  logic          req_valid,
    output logic          req_ready,

    // Product port
    output product_t      product,
    output logic          product_valid,
    input  logic          product_ready
);

    logic  load;
    logic  step_en;
    step_t step_index;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    mult_controller u_controller (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .product_valid (product_valid),
        .product_ready (product_ready),
        .load          (load),
        .step_en       (step_en),
        .step_index    (step_index)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    // Product is the accumulator, stable while DONE
    shift_add_datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .step_en    (step_en),
        .step_index (step_index),
        .req        (req),
        .product    (product)
    );

endmodule

`default_nettype wire

//--- sim/seq_multiplier_tb.sv
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier_tb
    import mult_pkg::*;
();

    localparam int    CLK_HALF  = 4;
    localparam int    MAX_GAP   = 3;
    localparam string TEST_FILE = "sim/mult_tests.txt";

    // Sixteen step cycles between the accept edge and product_valid
    localparam int LATENCY = OPERAND_WIDTH;

    typedef struct packed {
        mult_request_t req;
        product_t      expected;
        logic [7:0]    stall;
    } test_vector_t;

    logic          clk;
    logic          reset;
    mult_request_t req;
    logic          req_valid;
    logic          req_ready;
    product_t      product;
    logic          product_valid;
    logic          product_ready;

    test_vector_t  tests[$];
    string         test_names[$];
    int            error_count;
    int            passed_tests;
    int            failed_tests;
    int            cycle_count = 0;
    int            cycle_limit = 1000;

    seq_multiplier u_dut (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .product       (product),
        .product_valid (product_valid),
        .product_ready (product_ready)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("error: %0s expected %h actual %h", label, expected, actual);
        end
    endtask

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_tests(output bit ok);
        int           fd;
        int           count;
        int           stall;
        string        line;
        string        name;
        logic [15:0]  mcand;
        logic [15:0]  mplier;
        logic [31:0]  expected;
        test_vector_t vec;
        ok = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the test file %0s", TEST_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 1 && line[0] != "#") begin
                    count = $sscanf(line, "%s %h %h %h %d",
                                    name, mcand, mplier, expected, stall);
                    if (count == 5) begin
                        vec.req.multiplicand = mcand;
                        vec.req.multiplier   = mplier;
                        vec.expected         = expected;
                        vec.stall            = 8'(stall);
                        tests.push_back(vec);
                        test_names.push_back(name);
                    end else begin
                        error_count++;
                        $display("badly formed line in the test file: %0s", line);
                    end
                end
            end
            $fclose(fd);
            ok = (tests.size() > 0);
        end
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        check_value("reset req_ready", 32'd1, 32'(req_ready));
        check_value("reset product_valid", 32'd0, 32'(product_valid));
        check_value("reset product", 32'd0, product);
        if (error_count == errors_before) begin
            passed_tests++;
            $display("test reset: ok");
        end else begin
            failed_tests++;
            $display("test reset: failed");
        end
    endtask

    task automatic run_test(input int idx);
        string        name;
        test_vector_t vec;
        int           errors_before;
        int           gap;
        int           latency;
        product_t     held;
        name          = test_names[idx];
        vec           = tests[idx];
        errors_before = error_count;
        gap           = int'($urandom % (MAX_GAP + 1));
        repeat (gap) next_cycle();

        req       = vec.req;
        req_valid = 1'b1;
        while (!req_ready) next_cycle();
        next_cycle();

        // Accepted; operands on req no longer matter
        req_valid = 1'b0;
        req       = mult_request_t'($urandom);
        latency   = 0;
        while (!product_valid && latency <= LATENCY + 8) begin
            check_value({name, " req_ready while busy"}, 32'd0, 32'(req_ready));
            next_cycle();
            latency++;
        end
        check_value({name, " latency"}, LATENCY, latency);

        // Back-pressure must hold the result
        held = product;
        repeat (vec.stall) begin
            next_cycle();
            check_value({name, " product_valid in stall"}, 32'd1, 32'(product_valid));
            check_value({name, " product in stall"}, held, product);
            check_value({name, " req_ready in stall"}, 32'd0, 32'(req_ready));
        end
        check_value({name, " product"}, vec.expected, product);

        product_ready = 1'b1;
        next_cycle();
        product_ready = 1'b0;
        check_value({name, " product_valid after take"}, 32'd0, 32'(product_valid));
        check_value({name, " req_ready after take"}, 32'd1, 32'(req_ready));

        if (error_count == errors_before) begin
            passed_tests++;
            $display("test %0s: ok", name);
        end else begin
            failed_tests++;
            $display("test %0s: failed", name);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        bit loaded;
        int max_stall;
        void'($urandom(32'hd2089107));
        clk           = 1'b0;
        reset         = 1'b0;
        req           = '0;
        req_valid     = 1'b0;
        product_ready = 1'b0;
        error_count   = 0;
        passed_tests  = 0;
        failed_tests  = 0;
        max_stall     = 0;
        load_tests(loaded);
        if (!loaded) begin
            $display("no usable tests were read from %0s", TEST_FILE);
            $display("=== FAIL ===");
            $finish;
        end else begin
            foreach (tests[i]) begin
                if (int'(tests[i].stall) > max_stall) begin
                    max_stall = int'(tests[i].stall);
                end
            end
            cycle_limit = tests.size() * (17 + max_stall + 8) + 100;
            repeat (2) @(posedge clk);
            #1;
            reset = 1'b1;
            check_reset_state();
            foreach (tests[i]) begin
                run_test(i);
            end
            $display("%0d tests, %0d passed, %0d failed, %0d errors",
                     passed_tests + failed_tests, passed_tests, failed_tests, error_count);
            if (failed_tests == 0 && error_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/mult_tests.txt
# name  multiplicand(hex16)  multiplier(hex16)  expected_product(hex32)  stall_cycles(dec)
# Operands and product are two's complement
zero_zero            0000 0000 00000000 0
one_one              0001 0001 00000001 0
small_pos            0003 0005 0000000f 1
zero_times_max       0000 7fff 00000000 0
max_times_zero       7fff 0000 00000000 2
max_squared          7fff 7fff 3fff0001 0
pos_shifted          1234 0010 00012340 3
pos_large            00ff 0101 0000ffff 0
alt_bits             5555 0003 0000ffff 1
min_squared          8000 8000 40000000 4
min_times_one        8000 0001 ffff8000 0
one_times_min        0001 8000 ffff8000 2
neg_one_squared      ffff ffff 00000001 0
neg_times_pos        fffe 0003 fffffffa 5
pos_times_neg        0003 fffe fffffffa 0
min_times_max        8000 7fff c0008000 1
max_times_min        7fff 8000 c0008000 0
min_times_neg_one    8000 ffff 00008000 6
neg_one_times_min    ffff 8000 00008000 0
neg_squared          ff00 ff00 00010000 2
near_min_times_two   8001 0002 ffff0002 0
pos_times_neg_one    1234 ffff ffffedcc 3
neg_hundred          ff9c 0064 ffffd8f0 0
byte_squared         00ff 00ff 0000fe01 0
after_negative       0001 0001 00000001 0
long_stall           0007 0009 0000003f 7

//--- project.f
source/mult_pkg.sv
source/mult_controller.sv
source/shift_add_datapath.sv
source/seq_multiplier.sv
sim/seq_multiplier_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    -f project.f \
    --top-module seq_multiplier_tb \
    -o seq_multiplier_tb

./obj_dir/seq_multiplier_tb | tee "$LOG"

# The testbench prints the pass line only when every check held
if grep -q "^=== PASS ===$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
